// ==== rtl/br_pkg.sv ====
/*
 * Branch resolution unit shared definitions
 * Widths, branch class encoding and the records passed between the three stages
 */

package br_pkg;

	// ============================================================
	// Widths and fixed addresses
	// ============================================================

	localparam int ADDR_W = 32;
	localparam int BNO_W = 5;

	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [ADDR_W-1:0] value_t;
	typedef logic [BNO_W-1:0] bno_t;
	typedef logic [31:0] instr_t;

	// Target used when the class is not recognized, same as the reset vector
	localparam addr_t RSTPC = 32'hFFFC_0000;

	// Size of one instruction, so the fall-through address is pc plus this
	localparam addr_t INSN_BYTES = 32'd4;

	// Instruction word layout used here
	// bits 2:0   base register selector, 0 = zero and 7 = pc
	// bits 20:8  conditional branch displacement in words
	// bits 29:8  branch-and-link displacement in words
	// bit 30     constant is full width
	// bit 31     return-stack index for exception return
	// bits 12:8  exception return adjust count in words

	typedef enum logic [3:0] {
		BRC_NONE  = 4'd0,
		BRC_BCCD  = 4'd1,
		BRC_BCCR  = 4'd2,
		BRC_BCCC  = 4'd3,
		BRC_BL    = 4'd4,
		BRC_BLRLR = 4'd5,
		BRC_BLRLC = 4'd6,
		BRC_RET   = 4'd7,
		BRC_ERET  = 4'd8
	} brclass_t;

	// ============================================================
	// Stage records
	// ============================================================

	// One resolved branch as it leaves the issue logic
	typedef struct packed {
		logic valid;
		brclass_t brclass;
		instr_t ir;
		addr_t pc;
		logic [BNO_W-1:0] bno_t;
		logic [BNO_W-1:0] bno_f;
		logic bt;
		addr_t pred_target;
		logic takb;
		value_t arga;
		value_t argb;
		value_t argi;
	} br_req_t;

	// Base and displacement ready for the adder
	typedef struct packed {
		logic valid;
		logic is_cond;
		addr_t base;
		value_t disp;
		addr_t pc;
		logic [BNO_W-1:0] bno_t;
		logic [BNO_W-1:0] bno_f;
		logic bt;
		addr_t pred_target;
		logic takb;
	} br_opnd_t;

	// Both candidate next addresses
	typedef struct packed {
		logic valid;
		addr_t dstpc;
		addr_t actual_next;
		addr_t pred_next;
		logic taken;
		logic [BNO_W-1:0] bno_t;
		logic [BNO_W-1:0] bno_f;
	} br_tgt_t;

	// Resolution result handed back to the front end
	typedef struct packed {
		logic valid;
		logic miss;
		addr_t misspc;
		addr_t dstpc;
		bno_t stomp_bno;
	} br_res_t;

endpackage

// ==== rtl/br_operand_stage.sv ====
/*
 * Branch resolution stage 1
 * Picks the base value and builds the displacement for every branch class
 */

`timescale 1ns/10ps

module br_operand_stage
	import br_pkg::*;
(
	input logic clk,
	input logic rst,
	input br_req_t req,
	output br_opnd_t opnd
);

	addr_t sel_base;
	br_opnd_t nxt;

	// ============================================================
	// Base register selection
	// ============================================================

	// Selector 0 reads as zero and 7 as the branch pc, anything else is arga
	always_comb
	begin
		case (req.ir[2:0])
			3'd0:
				sel_base = '0;
			3'd7:
				sel_base = req.pc;
			default:
				sel_base = req.arga;
		endcase
	end

	// ============================================================
	// Displacement per class
	// ============================================================

	always_comb
	begin
		nxt = '0;
		nxt.valid = req.valid;
		nxt.pc = req.pc;
		nxt.bno_t = req.bno_t;
		nxt.bno_f = req.bno_f;
		nxt.bt = req.bt;
		nxt.pred_target = req.pred_target;
		nxt.takb = req.takb;
		nxt.is_cond = 1'b0;
		nxt.base = sel_base;
		nxt.disp = '0;

		case (req.brclass)
			BRC_BCCD:
			begin
				// 13-bit word displacement, sign extended and scaled to bytes
				nxt.is_cond = 1'b1;
				nxt.disp = {{17{req.ir[20]}}, req.ir[20:8], 2'b00};
			end
			BRC_BCCR:
			begin
				nxt.is_cond = 1'b1;
				nxt.disp = {req.argb[ADDR_W-1:2], 2'b00};
			end
			BRC_BCCC:
			begin
				// At 32 bits the narrow constant sign extends to itself, so bit 30 is moot
				nxt.is_cond = 1'b1;
				nxt.disp = {req.argi[ADDR_W-1:2], 2'b00};
			end
			BRC_BL:
			begin
				// Link branches are always pc relative with a 22-bit word offset
				nxt.base = req.pc;
				nxt.disp = {{8{req.ir[29]}}, req.ir[29:8], 2'b00};
			end
			BRC_BLRLR:
				nxt.disp = {req.argb[ADDR_W-1:2], 2'b00};
			BRC_BLRLC:
				nxt.disp = {req.argi[ADDR_W-1:2], 2'b00};
			BRC_RET:
				nxt.disp = '0;
			BRC_ERET:
			begin
				// Two-entry return stack arrives on arga and argb
				nxt.base = req.ir[31] ? req.argb : req.arga;
				nxt.disp = {25'd0, req.ir[12:8], 2'b00};
			end
			default:
			begin
				// Unknown class goes to the reset vector
				nxt.base = RSTPC;
				nxt.disp = '0;
			end
		endcase
	end

	// Payload follows the request every cycle, only valid is cleared
	always_ff @(posedge clk)
	begin
		opnd <= nxt;
		if (rst)
			opnd.valid <= 1'b0;
	end

	// The front end never predicts taken for something that is not a branch
	a_no_pred_on_none: assert property (@(posedge clk) disable iff (rst)
		req.valid |-> !(req.brclass == BRC_NONE && req.bt))
		else $error("Predicted taken on a request with no branch class");

endmodule

// ==== rtl/br_target_stage.sv ====
/*
 * Branch resolution stage 2
 * Adds base and displacement and forms the actual and predicted next address
 */

`timescale 1ns/10ps

module br_target_stage
	import br_pkg::*;
(
	input logic clk,
	input logic rst,
	input br_opnd_t opnd,
	output br_tgt_t tgt
);

	addr_t dstpc;
	addr_t fall_pc;
	logic taken;
	br_tgt_t nxt;

	// ============================================================
	// Target and fall-through
	// ============================================================

	// Branch destination, wraps at the address width
	assign dstpc = opnd.base + opnd.disp;

	// The only place the sequential address is formed
	assign fall_pc = opnd.pc + INSN_BYTES;

	// Only conditional branches look at the resolved direction
	// Every other class always leaves the sequential path
	assign taken = opnd.is_cond ? opnd.takb : 1'b1;

	always_comb
	begin
		nxt.valid = opnd.valid;
		nxt.dstpc = dstpc;
		nxt.taken = taken;
		nxt.bno_t = opnd.bno_t;
		nxt.bno_f = opnd.bno_f;

		// Where execution really goes next
		nxt.actual_next = taken ? dstpc : fall_pc;

		// Where the front end went, given its direction guess
		nxt.pred_next = opnd.bt ? opnd.pred_target : fall_pc;
	end

	// ============================================================
	// Stage register
	// ============================================================

	always_ff @(posedge clk)
	begin
		tgt <= nxt;
		if (rst)
			tgt.valid <= 1'b0;
	end

endmodule

// ==== rtl/br_miss_stage.sv ====
/*
 * Branch resolution stage 3
 * Detects a mispredict and reports the redirect address and the tag to squash
 */

`timescale 1ns/10ps

module br_miss_stage
	import br_pkg::*;
(
	input logic clk,
	input logic rst,
	input br_tgt_t tgt,
	output br_res_t res
);

	logic miss;
	bno_t stomp_bno;
	br_res_t nxt;

	// ============================================================
	// Mispredict detection
	// ============================================================

	// Any difference in the next address is a miss, direction or target
	assign miss = tgt.valid && (tgt.actual_next != tgt.pred_next);

	// A taken branch kills the not-taken path and the other way round
	always_comb
	begin
		if (!miss)
			stomp_bno = '0;
		else if (tgt.taken)
			stomp_bno = tgt.bno_f;
		else
			stomp_bno = tgt.bno_t;
	end

	always_comb
	begin
		nxt.valid = tgt.valid;
		nxt.miss = miss;
		// Redirect always points at the correct path, miss or not
		nxt.misspc = tgt.actual_next;
		nxt.dstpc = tgt.dstpc;
		nxt.stomp_bno = stomp_bno;
	end

	// ============================================================
	// Result register
	// ============================================================

	always_ff @(posedge clk)
	begin
		res <= nxt;
		if (rst)
		begin
			res.valid <= 1'b0;
			res.miss <= 1'b0;
		end
	end

	// A miss is only reported alongside a real branch
	a_miss_has_valid: assert property (@(posedge clk) disable iff (rst)
		res.miss |-> res.valid)
		else $error("Miss reported without a valid result");

	// Squash tag is quiet unless a redirect happens
	a_stomp_only_on_miss: assert property (@(posedge clk) disable iff (rst)
		!res.miss |-> (res.stomp_bno == '0))
		else $error("Stomp tag %h set without a miss", res.stomp_bno);

endmodule

// ==== rtl/br_resolve_top.sv ====
/*
 * Branch resolution unit
 * Three registered stages, one branch accepted per cycle with three cycles latency
 */

`timescale 1ns/10ps

module br_resolve_top
	import br_pkg::*;
(
	input logic clk,
	input logic rst,
	input br_req_t req,
	output br_res_t res
);

	br_opnd_t opnd;
	br_tgt_t tgt;

	// ============================================================
	// Pipeline
	// ============================================================

	// Base and displacement
	br_operand_stage u_operand (
		.clk  (clk),
		.rst  (rst),
		.req  (req),
		.opnd (opnd)
	);

	// Target add and next address forming
	br_target_stage u_target (
		.clk  (clk),
		.rst  (rst),
		.opnd (opnd),
		.tgt  (tgt)
	);

	// Compare against the prediction
	br_miss_stage u_miss (
		.clk (clk),
		.rst (rst),
		.tgt (tgt),
		.res (res)
	);

endmodule

// ==== dv/br_model.svh ====
/*
 * Branch resolution reference model and stimulus row type
 * Included inside a testbench scope that imports br_pkg
 */

`ifndef BR_MODEL_SVH
`define BR_MODEL_SVH

// One table row, a request and the result it must produce
typedef struct packed {
	br_req_t req;
	br_res_t exp;
} br_vec_t;

// Untimed version of the three stages
function automatic br_res_t br_model(input br_req_t r);
	addr_t sel;
	addr_t base;
	value_t disp;
	addr_t dst;
	addr_t fall;
	addr_t act;
	addr_t prd;
	logic cond;
	logic tk;
	br_res_t o;

	case (r.ir[2:0])
		3'd0: sel = '0;
		3'd7: sel = r.pc;
		default: sel = r.arga;
	endcase
	base = sel;
	disp = '0;
	cond = (r.brclass == BRC_BCCD) || (r.brclass == BRC_BCCR) || (r.brclass == BRC_BCCC);
	case (r.brclass)
		BRC_BCCD: disp = {{17{r.ir[20]}}, r.ir[20:8], 2'b00};
		BRC_BCCR, BRC_BLRLR: disp = {r.argb[31:2], 2'b00};
		BRC_BCCC, BRC_BLRLC: disp = {r.argi[31:2], 2'b00};
		BRC_BL:
		begin
			base = r.pc;
			disp = {{8{r.ir[29]}}, r.ir[29:8], 2'b00};
		end
		BRC_RET: disp = '0;
		BRC_ERET:
		begin
			base = r.ir[31] ? r.argb : r.arga;
			disp = {25'd0, r.ir[12:8], 2'b00};
		end
		default: base = RSTPC;
	endcase
	dst = base + disp;
	fall = r.pc + 32'd4;
	tk = cond ? r.takb : 1'b1;
	act = tk ? dst : fall;
	prd = r.bt ? r.pred_target : fall;
	o.valid = r.valid;
	o.miss = r.valid && (act != prd);
	o.misspc = act;
	o.dstpc = dst;
	o.stomp_bno = !o.miss ? '0 : (tk ? r.bno_f : r.bno_t);
	return o;
endfunction

`endif

// ==== dv/br_resolve_tb.sv ====
/*
 * Testbench for the branch resolution unit
 * Directed and random branches from a table, checked against the reference model
 */

`timescale 1ns/10ps

module br_resolve_tb
	import br_pkg::*;
();

	`include "br_model.svh"

	localparam int CLK_PERIOD = 4;
	localparam int RST_CYCLES = 3;
	localparam int LAT = 3;
	localparam int N_RAND = 40;
	localparam int SEED = 44854;

	logic clk;
	logic rst;
	br_req_t req;
	br_res_t res;

	// Table rows, and for every valid row in flight its result, row number and issue cycle
	br_vec_t tbl[$];
	br_res_t exp_q[$];
	int row_q[$];
	int cyc_q[$];
	int cyc = 0;
	int n_pass = 0;
	int n_fail = 0;
	bit cur_bad;
	bit tbl_ready = 1'b0;

	br_resolve_top dut (
		.clk (clk),
		.rst (rst),
		.req (req),
		.res (res)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#(CLK_PERIOD / 2) clk = ~clk;
	end

	always @(posedge clk)
		cyc <= cyc + 1;

	// ============================================================
	// Checks and reporting
	// ============================================================

	task automatic check_addr(input string name, input addr_t got, input addr_t exp);
		if (got !== exp)
		begin
			$display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
			cur_bad = 1'b1;
		end
	endtask

	task automatic check_bno(input string name, input bno_t got, input bno_t exp);
		if (got !== exp)
		begin
			$display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
			cur_bad = 1'b1;
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp)
		begin
			$display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
			cur_bad = 1'b1;
		end
	endtask

	function automatic void report_test(input string label);
		$display("Test %s: %s", label, cur_bad ? "FAIL" : "ok");
		if (cur_bad)
			n_fail++;
		else
			n_pass++;
	endfunction

	// ============================================================
	// Stimulus table
	// ============================================================

	// Valid request whose pred_target is the true destination unless changed later
	function automatic br_req_t make_req(input brclass_t cls, input instr_t ir, input addr_t pc,
		input value_t arga, input value_t argb, input value_t argi, input logic bt,
		input logic takb);
		br_req_t r;
		br_res_t m;
		r = '0;
		r.valid = 1'b1;
		r.brclass = cls;
		r.ir = ir;
		r.pc = pc;
		r.bno_t = 5'h0A;
		r.bno_f = 5'h15;
		r.bt = bt;
		r.takb = takb;
		r.arga = arga;
		r.argb = argb;
		r.argi = argi;
		m = br_model(r);
		r.pred_target = m.dstpc;
		return r;
	endfunction

	function automatic void push_row(input br_req_t r);
		br_vec_t v;
		v.req = r;
		v.exp = br_model(r);
		tbl.push_back(v);
	endfunction

	task automatic build_table();
		br_req_t r;
		brclass_t cls;
		instr_t ir;
		brclass_t cond_cls[3];
		brclass_t base_cls[5];
		brclass_t unc_cls[6];
		logic [2:0] sels[3];
		cond_cls = '{BRC_BCCD, BRC_BCCR, BRC_BCCC};
		base_cls = '{BRC_BCCR, BRC_BCCC, BRC_BLRLR, BRC_BLRLC, BRC_RET};
		unc_cls = '{BRC_BL, BRC_BLRLR, BRC_BLRLC, BRC_RET, BRC_ERET, BRC_ERET};
		sels = '{3'd0, 3'd7, 3'd3};
		// Every bt and takb pair, backward displacement off the pc
		foreach (cond_cls[c])
			for (int p = 0; p < 4; p++)
				push_row(make_req(cond_cls[c], (32'h1F80 << 8) | 32'd7,
					32'h0000_4000 + c * 32'h100, 32'h0001_0000, 32'hFFFF_FF43,
					32'hFFFF_F800, p[1], p[0]));
		// Zero, pc and arga as base with negative register and constant offsets
		foreach (base_cls[c])
			foreach (sels[s])
				push_row(make_req(base_cls[c], {29'd0, sels[s]}, 32'h0002_0000 + c * 32'h40,
					32'h0800_0010, 32'hFFFF_FE01, 32'hFFFF_0003, 1'b1, 1'b1));
		// Correct target, wrong target and predicted not taken; the last entry is ERET index 1
		foreach (unc_cls[c])
			for (int k = 0; k < 3; k++)
			begin
				ir = {(c == 5), 1'b0, 22'h3FFF10, 5'd0, 3'd3};
				r = make_req(unc_cls[c], ir, 32'h0003_0000 + c * 32'h80, 32'h0005_0100,
					32'h0006_0200, 32'h0000_7FFC, (k != 2), 1'b0);
				if (k == 1)
					r.pred_target = r.pred_target + 32'd8;
				push_row(r);
			end
		push_row(make_req(BRC_NONE, 32'd0, 32'h0000_5000, 32'd0, 32'd0, 32'd0, 1'b0, 1'b0));
		// Random branches, roughly one in four followed by an idle cycle
		for (int i = 0; i < N_RAND; i++)
		begin
			cls = brclass_t'(4'd1 + 4'($urandom_range(7)));
			r = make_req(cls, $urandom(), $urandom() & 32'hFFFF_FFFC, $urandom(), $urandom(),
				$urandom(), 1'($urandom_range(1)), 1'($urandom_range(1)));
			r.bno_t = 5'($urandom());
			r.bno_f = 5'($urandom());
			if ($urandom_range(1) == 0)
				r.pred_target = $urandom() & 32'hFFFF_FFFC;
			push_row(r);
			if ($urandom_range(3) == 0)
			begin
				r.valid = 1'b0;
				push_row(r);
			end
		end
	endtask

	// ============================================================
	// Main sequence
	// ============================================================

	initial
	begin
		rst = 1'b1;
		req = '0;
		void'($urandom(SEED));
		build_table();
		@(posedge clk);
		// A mispredicting return held on the input during reset must never reach res
		req <= make_req(BRC_RET, 32'd3, 32'h0000_1000, 32'h0000_2000, 32'd0, 32'd0,
			1'b0, 1'b0);
		repeat (RST_CYCLES - 1) @(posedge clk);
		rst <= 1'b0;
		req <= '0;
		// Nothing may come out while the pipeline is idle
		cur_bad = 1'b0;
		repeat (4)
		begin
			@(posedge clk);
			check_flag("res.valid", res.valid, 1'b0);
			check_flag("res.miss", res.miss, 1'b0);
		end
		report_test("reset");
		tbl_ready = 1'b1;
		foreach (tbl[i])
		begin
			@(posedge clk);
			req <= tbl[i].req;
			if (tbl[i].req.valid)
			begin
				exp_q.push_back(tbl[i].exp);
				row_q.push_back(i);
				cyc_q.push_back(cyc);
			end
		end
		@(posedge clk);
		req <= '0;
		while (exp_q.size() != 0)
			@(posedge clk);
		// A few more cycles to catch any stray result
		repeat (LAT + 2) @(posedge clk);
		$display("Summary: %0d tests passed, %0d tests failed", n_pass, n_fail);
		if (n_fail == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

	// Results are sampled on the edge after they are registered, hence LAT plus one
	always @(posedge clk)
	begin
		br_res_t e;
		brclass_t cls;
		int row;
		int issued;
		if (!rst && res.valid)
		begin
			if (exp_q.size() == 0)
			begin
				$display("Result arrived with no request outstanding, misspc %h", res.misspc);
				n_fail++;
			end
			else
			begin
				e = exp_q.pop_front();
				row = row_q.pop_front();
				issued = cyc_q.pop_front();
				cls = tbl[row].req.brclass;
				cur_bad = 1'b0;
				check_flag("res.miss", res.miss, e.miss);
				check_addr("res.misspc", res.misspc, e.misspc);
				check_addr("res.dstpc", res.dstpc, e.dstpc);
				check_bno("res.stomp_bno", res.stomp_bno, e.stomp_bno);
				if (cyc - issued != LAT + 1)
				begin
					$display("Row %0d came out %0d cycles after it was accepted instead of %0d",
						row, cyc - issued - 1, LAT);
					cur_bad = 1'b1;
				end
				report_test($sformatf("%0d %s", row, cls.name()));
			end
		end
	end

	// Whole table plus a margin, counted from the first request
	initial
	begin
		wait (tbl_ready);
		#((tbl.size() + 20) * CLK_PERIOD);
		$display("Watchdog fired, results stopped arriving with %0d branches outstanding",
			exp_q.size());
		$display("Regression failed");
		$finish;
	end

endmodule

// ==== all.f ====
+incdir+dv
rtl/br_pkg.sv
rtl/br_operand_stage.sv
rtl/br_target_stage.sv
rtl/br_miss_stage.sv
rtl/br_resolve_top.sv
dv/br_resolve_tb.sv

// ==== Makefile ====
# Verilator build and run for the branch resolution unit

SIM      = verilator
TOP      = br_resolve_tb
FILELIST = all.f
FLAGS    = --binary --timing --assert --timescale 1ns/10ps --top-module $(TOP)
OBJ_DIR  = obj_dir
BIN      = $(OBJ_DIR)/V$(TOP)
LOG      = sim.log
SRCS     = $(shell grep -v '^+' $(FILELIST)) dv/br_model.svh

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -q "Regression failed" $(LOG); then \
		echo "Simulation reported a failure"; \
		exit 1; \
	fi
	@grep -q "Regression passed" $(LOG) || (echo "Simulation ended without a result"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
